// ==== src/adc_bus_regs.sv ====
/*
  Host register window of the ADC controller.
  Decodes the address window, holds one pending command,
  tracks busy until the carrying frame ends and returns readback.
*/
`timescale 1ns/1ps

module adc_bus_regs #(
  parameter int position = 0
) (
  input  logic              sclk,
  input  logic              reset,
  input  adc_pkg::host_req_t req,
  input  logic              cmd_taken,
  input  adc_pkg::adc_word_t rd_word,
  output adc_pkg::adc_word_t cmd_word,
  output logic              cmd_pending,
  output logic              bank_clear,
  output adc_pkg::chan_t    rd_chan,
  output adc_pkg::adc_word_t data_out,
  output logic              rd_valid,
  output logic              busy
);
  import adc_pkg::*;

  // Window base, one 256-word page per position.
  localparam bus_addr_t base_addr = bus_addr_t'(position * 256);
  localparam int off_w = $bits(reg_offset_e);
  localparam int addr_w = $bits(bus_addr_t);
  localparam int cnt_w = $clog2(frame_cycles);

  logic [off_w-1:0] offset;
  logic             page_hit;
  logic             chan_hit;
  logic             cmd_accept;
  logic             carrying;
  logic [cnt_w-1:0] frame_cnt;

  // Low byte is the offset, upper bits pick the page.
  assign offset   = req.addr[off_w-1:0];
  assign page_hit = (req.addr[addr_w-1:off_w] == base_addr[addr_w-1:off_w]);

  // Sample registers occupy offsets 2 to 9.
  assign chan_hit = page_hit && (offset >= off_chan0) && (offset <= off_chan7);
  assign rd_chan  = chan_t'(offset - off_chan0);

  // Command write, dropped while busy.
  assign cmd_accept = req.wr && page_hit && (offset == off_cmd) && !busy;

  // Reset command clears the bank at this same edge.
  assign bank_clear = req.wr && page_hit && (offset == off_reset) &&
                      (req.wdata == cmd_reset);

  // Command word itself.
  always_ff @(posedge sclk) begin
    if (cmd_accept) begin
      cmd_word <= req.wdata;
    end
  end

  // Pending flag and busy tracking.
  always_ff @(posedge sclk) begin
    if (reset) begin
      cmd_pending <= 1'b0;
      busy        <= 1'b0;
      carrying    <= 1'b0;
      frame_cnt   <= '0;
    end else begin
      // Accept and take cannot meet, pending implies busy.
      if (cmd_accept) begin
        cmd_pending <= 1'b1;
        busy        <= 1'b1;
      end else if (cmd_taken) begin
        cmd_pending <= 1'b0;
      end
      // Engine loaded it, count out the cs-high cycles.
      if (cmd_taken) begin
        carrying  <= 1'b1;
        frame_cnt <= cnt_w'(frame_cycles - 1);
      end else if (carrying) begin
        if (frame_cnt == '0) begin
          // Last cs-high cycle, busy drops in the gap.
          carrying <= 1'b0;
          busy     <= 1'b0;
        end else begin
          frame_cnt <= frame_cnt - 1'b1;
        end
      end
    end
  end

  // Read strobe answered one cycle later.
  always_ff @(posedge sclk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= req.rd;
    end
  end

  // Only sample offsets return data, all else reads 0.
  always_ff @(posedge sclk) begin
    if (req.rd) begin
      data_out <= chan_hit ? rd_word : '0;
    end
  end

  // Engine only takes a command that was offered.
  taken_needs_pending: assert property (
    @(posedge sclk) disable iff (reset) cmd_taken |-> cmd_pending
  );

endmodule

// ==== src/adc_control.sv ====
/*
  Top level of the serial ADC controller.
  Joins the host register window, the frame engine
  and the sample bank.
*/
`timescale 1ns/1ps

module adc_control #(
  parameter int position = 0
) (
  input  logic               sclk,
  input  logic               reset,
  input  logic               wr,
  input  logic               rd,
  input  adc_pkg::bus_addr_t addr,
  input  adc_pkg::adc_word_t data_in,
  output adc_pkg::adc_word_t data_out,
  output logic               rd_valid,
  output logic               busy,
  output logic               cs,
  output logic               adc_sclk,
  output logic               adc_din,
  input  logic               adc_dout
);
  import adc_pkg::*;

  host_req_t req;
  adc_word_t cmd_word;
  logic      cmd_pending;
  logic      cmd_taken;
  logic      bank_clear;
  chan_t     rd_chan;
  adc_word_t rd_word;
  rx_frame_t rx;
  logic      rx_valid;

  // Host pins bundled into one request.
  assign req = '{wr: wr, rd: rd, addr: addr, wdata: data_in};

  adc_bus_regs #(
    .position(position)
  ) regs_i (
    .sclk       (sclk),
    .reset      (reset),
    .req        (req),
    .cmd_taken  (cmd_taken),
    .rd_word    (rd_word),
    .cmd_word   (cmd_word),
    .cmd_pending(cmd_pending),
    .bank_clear (bank_clear),
    .rd_chan    (rd_chan),
    .data_out   (data_out),
    .rd_valid   (rd_valid),
    .busy       (busy)
  );

  adc_frame_engine engine_i (
    .sclk       (sclk),
    .reset      (reset),
    .cmd_word   (cmd_word),
    .cmd_pending(cmd_pending),
    .cmd_taken  (cmd_taken),
    .cs         (cs),
    .adc_sclk   (adc_sclk),
    .adc_din    (adc_din),
    .adc_dout   (adc_dout),
    .rx         (rx),
    .rx_valid   (rx_valid)
  );

  adc_sample_bank bank_i (
    .sclk    (sclk),
    .reset   (reset),
    .rx      (rx),
    .rx_valid(rx_valid),
    .clear   (bank_clear),
    .rd_chan (rd_chan),
    .rd_word (rd_word)
  );

endmodule

// ==== src/adc_frame_engine.sv ====
/*
  Serial frame engine for the ADC.
  Runs frames back to back, shifting a command or idle word out
  on adc_din MSB first while capturing adc_dout, then hands the
  received word to the sample bank in the gap cycle.
*/
`timescale 1ns/1ps

module adc_frame_engine (
  input  logic               sclk,
  input  logic               reset,
  input  adc_pkg::adc_word_t cmd_word,
  input  logic               cmd_pending,
  output logic               cmd_taken,
  output logic               cs,
  output logic               adc_sclk,
  output logic               adc_din,
  input  logic               adc_dout,
  output adc_pkg::rx_frame_t rx,
  output logic               rx_valid
);
  import adc_pkg::*;

  localparam int bit_w = $clog2(frame_bits);
  localparam int chan_w = $bits(chan_t);

  // State sets the registered pins for the next cycle.
  typedef enum logic [1:0] {
    st_load,
    st_shift,
    st_gap
  } state_e;

  state_e           state;
  logic [bit_w-1:0] bit_cnt;
  adc_word_t        out_shift;
  adc_word_t        in_shift;
  adc_word_t        next_word;

  // Command wins over the idle word.
  assign next_word = cmd_pending ? cmd_word : idle_word;
  // Load sits in the cs-low gap cycle.
  assign cmd_taken = (state == st_load) && cmd_pending;

  // MSB of the out register drives the pin.
  assign adc_din = out_shift[frame_bits-1];

  // Tag rides in the top bits of the reply.
  assign rx.chan = in_shift[frame_bits-1 -: chan_w];
  assign rx.word = in_shift;

  always_ff @(posedge sclk) begin
    if (reset) begin
      state     <= st_load;
      cs        <= 1'b0;
      adc_sclk  <= 1'b0;
      bit_cnt   <= '0;
      out_shift <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        st_load: begin
          // Open the frame, first bit low phase.
          cs        <= 1'b1;
          adc_sclk  <= 1'b0;
          bit_cnt   <= '0;
          out_shift <= next_word;
          state     <= st_shift;
        end
        st_shift: begin
          if (!adc_sclk) begin
            // Low phase done, raise sclk.
            adc_sclk <= 1'b1;
            if (bit_cnt == bit_w'(frame_bits - 1)) begin
              state <= st_gap;
            end
          end else begin
            // High phase done, next bit on din.
            adc_sclk  <= 1'b0;
            bit_cnt   <= bit_cnt + 1'b1;
            out_shift <= {out_shift[frame_bits-2:0], 1'b0};
          end
        end
        st_gap: begin
          // Last high phase now, close the frame.
          cs        <= 1'b0;
          adc_sclk  <= 1'b0;
          out_shift <= '0;
          rx_valid  <= 1'b1;
          state     <= st_load;
        end
        default: begin
          state <= st_load;
        end
      endcase
    end
  end

  // Sample adc_dout in the high cycle of each bit.
  always_ff @(posedge sclk) begin
    if (cs && adc_sclk) begin
      in_shift <= {in_shift[frame_bits-2:0], adc_dout};
    end
  end

  // Frame length seen on the pins.
  cs_frame_len: assert property (
    @(posedge sclk) disable iff (reset)
    $rose(cs) |-> cs [*frame_cycles] ##1 !cs
  );

  // No clock edges outside a frame.
  sclk_idle_low: assert property (
    @(posedge sclk) disable iff (reset) !cs |-> !adc_sclk
  );

endmodule

// ==== src/adc_pkg.sv ====
/*
  Shared definitions for the serial ADC controller.
  Word and address types, host register offsets,
  command codes and serial frame constants.
*/
package adc_pkg;

  // Serial frame word, also the host data width.
  typedef logic [15:0] adc_word_t;
  // Host address bus.
  typedef logic [18:0] bus_addr_t;
  // Channel tag, top three bits of a received frame.
  typedef logic [2:0] chan_t;

  // Channels on the chip.
  localparam int num_chan = 8;
  // Bits shifted per frame.
  localparam int frame_bits = 16;
  // Two sclk cycles per serial bit.
  localparam int frame_cycles = 2 * frame_bits;

  // Offsets inside the host window.
  typedef enum logic [7:0] {
    off_reset = 8'd0,
    off_cmd   = 8'd1,
    off_chan0 = 8'd2,
    off_chan1 = 8'd3,
    off_chan2 = 8'd4,
    off_chan3 = 8'd5,
    off_chan4 = 8'd6,
    off_chan5 = 8'd7,
    off_chan6 = 8'd8,
    off_chan7 = 8'd9
  } reg_offset_e;

  // Written at the reset offset to wipe the sample bank.
  localparam adc_word_t cmd_reset = 16'd1;
  // Shifted out when no command is waiting.
  localparam adc_word_t idle_word = 16'd0;

  // One host access per cycle.
  typedef struct packed {
    logic      wr;
    logic      rd;
    bus_addr_t addr;
    adc_word_t wdata;
  } host_req_t;

  // One received frame, tag split out.
  typedef struct packed {
    chan_t     chan;
    adc_word_t word;
  } rx_frame_t;

endpackage

// ==== src/adc_sample_bank.sv ====
/*
  Sample bank of the ADC controller.
  Keeps the latest frame per channel tag and
  answers combinational reads from the host window.
*/
`timescale 1ns/1ps

module adc_sample_bank (
  input  logic               sclk,
  input  logic               reset,
  input  adc_pkg::rx_frame_t rx,
  input  logic               rx_valid,
  input  logic               clear,
  input  adc_pkg::chan_t     rd_chan,
  output adc_pkg::adc_word_t rd_word
);
  import adc_pkg::*;

  // One word per channel.
  adc_word_t mem [num_chan];

  // Clear beats a write landing in the same cycle.
  always_ff @(posedge sclk) begin
    if (reset || clear) begin
      for (int i = 0; i < num_chan; i++) begin
        mem[i] <= '0;
      end
    end else if (rx_valid) begin
      // Filed by the tag the chip sent.
      mem[rx.chan] <= rx.word;
    end
  end

  // Read port, no latency.
  assign rd_word = mem[rd_chan];

endmodule

// ==== verif/adc_control_tb.sv ====
/*
  Testbench for the serial ADC controller.
  Host reads and writes against the DUT, a chip model on the
  serial pins, and checks on frame shape, commands and readback.
*/
`timescale 1ns/1ps

module adc_control_tb;
  import adc_pkg::*;

  localparam int position = 2;
  localparam bus_addr_t base = bus_addr_t'(position * 256);
  // Cycles any single wait may take.
  localparam int wait_limit = 200;

  logic      sclk;
  logic      reset;
  logic      wr;
  logic      rd;
  bus_addr_t addr;
  adc_word_t data_in;
  adc_word_t data_out;
  logic      rd_valid;
  logic      busy;
  logic      cs;
  logic      adc_sclk;
  logic      adc_din;
  logic      adc_dout;

  int        errors;
  int        timeouts;
  bit        aborted;
  // Cycles spent waiting for the chip's frame count.
  int        waited;
  // Channels filed since the last bank clear.
  logic [num_chan-1:0] fresh;
  // Frame shape monitor.
  int        high_cycles;
  int        rises;
  int        gap_cycles;
  int        frames_done;
  logic      prev_cs;
  logic      prev_sclk;
  logic      prev_din;

  adc_control #(
    .position(position)
  ) dut_i (
    .sclk    (sclk),
    .reset   (reset),
    .wr      (wr),
    .rd      (rd),
    .addr    (addr),
    .data_in (data_in),
    .data_out(data_out),
    .rd_valid(rd_valid),
    .busy    (busy),
    .cs      (cs),
    .adc_sclk(adc_sclk),
    .adc_din (adc_din),
    .adc_dout(adc_dout)
  );

  adc_serial_model model_i (
    .cs      (cs),
    .adc_sclk(adc_sclk),
    .adc_din (adc_din),
    .adc_dout(adc_dout)
  );

  initial begin
    sclk = 1'b0;
    forever #5 sclk = ~sclk;
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t ns: %s", $time, msg);
  endtask

  // Stop waiting from here on.
  task automatic give_up(input string what);
    if (!aborted) begin
      timeouts++;
      $display("Timeout: %s within %0d cycles", what, wait_limit);
    end
    aborted = 1'b1;
  endtask

  // Returns in the gap cycle after the next frame.
  task automatic wait_frame_end();
    int n;
    n = 0;
    while (!cs && n < wait_limit && !aborted) begin
      @(negedge sclk);
      n++;
    end
    while (cs && n < wait_limit && !aborted) begin
      @(negedge sclk);
      n++;
    end
    if (n >= wait_limit) begin
      give_up("cs did not drop at a frame end");
    end
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy && n < wait_limit && !aborted) begin
      @(negedge sclk);
      n++;
    end
    if (n >= wait_limit) begin
      give_up("busy did not fall");
    end
  endtask

  // Single-cycle write strobe.
  task automatic host_write(input bus_addr_t a, input adc_word_t d);
    wr      = 1'b1;
    addr    = a;
    data_in = d;
    @(negedge sclk);
    wr = 1'b0;
  endtask

  // Single-cycle read strobe, data due one cycle later.
  task automatic check_read(input bus_addr_t a, input adc_word_t expected);
    int n;
    rd   = 1'b1;
    addr = a;
    @(negedge sclk);
    rd = 1'b0;
    n  = 0;
    while (!rd_valid && n < wait_limit) begin
      @(negedge sclk);
      n++;
    end
    if (n >= wait_limit) begin
      give_up("rd_valid did not rise");
    end else begin
      assert (n == 0) else flag_error($sformatf("rd_valid %0d cycles late", n));
      assert (data_out === expected) else flag_error(
        $sformatf("addr %h read %h, expected %h", a, data_out, expected));
    end
  endtask

  // All eight channels, empty unless filed since the clear.
  task automatic check_bank();
    adc_word_t expected;
    for (int k = 0; k < num_chan; k++) begin
      expected = fresh[k] ? model_i.last_sent[k] : '0;
      check_read(base + bus_addr_t'(off_chan0) + bus_addr_t'(k), expected);
    end
  endtask

  // Frame shape on the serial pins.
  always @(negedge sclk) begin
    if (!reset) begin
      if (cs) begin
        if (!prev_cs) begin
          if (frames_done > 0) begin
            assert (gap_cycles == 1) else flag_error(
              $sformatf("gap of %0d cycles between frames", gap_cycles));
          end
          high_cycles = 0;
          rises       = 0;
        end
        high_cycles++;
        if (adc_sclk && !prev_sclk) begin
          rises++;
        end
        // din only moves in the low half of a bit.
        if (adc_sclk) begin
          assert (adc_din === prev_din) else flag_error("adc_din moved with adc_sclk high");
        end
      end else begin
        if (prev_cs) begin
          assert (high_cycles == 2 * frame_bits) else flag_error(
            $sformatf("cs high for %0d cycles", high_cycles));
          assert (rises == frame_bits) else flag_error(
            $sformatf("%0d adc_sclk rising edges in a frame", rises));
          frames_done++;
          gap_cycles = 0;
        end
        gap_cycles++;
        assert (!adc_sclk) else flag_error("adc_sclk high with cs low");
      end
    end
    prev_cs   = cs;
    prev_sclk = adc_sclk;
    prev_din  = adc_din;
  end

  initial begin
    reset       = 1'b1;
    wr          = 1'b0;
    rd          = 1'b0;
    addr        = '0;
    data_in     = '0;
    errors      = 0;
    timeouts    = 0;
    aborted     = 1'b0;
    waited      = 0;
    fresh       = '0;
    high_cycles = 0;
    rises       = 0;
    gap_cycles  = 0;
    frames_done = 0;
    prev_cs     = 1'b0;
    prev_sclk   = 1'b0;
    prev_din    = 1'b0;
    repeat (10) @(negedge sclk);
    assert (cs === 1'b0 && adc_sclk === 1'b0 && adc_din === 1'b0 &&
            busy === 1'b0 && rd_valid === 1'b0) else flag_error("outputs not low in reset");
    reset = 1'b0;
    @(negedge sclk);
    assert (cs === 1'b1) else flag_error("first frame not started 1 cycle after reset");
    assert (busy === 1'b0) else flag_error("busy high with no command");
    // Nothing filed before the first frame ends.
    check_bank();

    // Command goes out as written.
    wait_frame_end();
    host_write(base + 1, 16'hA5C3);
    assert (busy === 1'b1) else flag_error("busy not high after command write");
    wait_busy_low();
    assert (cs === 1'b0) else flag_error("busy fell outside the gap cycle");
    assert (model_i.cmd_count == 1) else flag_error("chip did not see the command");
    assert (model_i.cmd_log[0] === 16'hA5C3) else flag_error(
      $sformatf("chip got %h, expected a5c3", model_i.cmd_log[0]));

    // Second command lands while busy and is dropped.
    host_write(base + 1, 16'h3C5A);
    host_write(base + 1, 16'h0F0F);
    wait_busy_low();
    assert (model_i.cmd_log[1] === 16'h3C5A) else flag_error(
      $sformatf("chip got %h, expected 3c5a", model_i.cmd_log[1]));
    wait_frame_end();
    wait_frame_end();
    assert (model_i.cmd_count == 2) else flag_error("write during busy reached the chip");

    // Readback once every channel has a reply.
    waited = 0;
    while (model_i.frame_count < 10 && waited < wait_limit && !aborted) begin
      @(negedge sclk);
      waited++;
    end
    if (waited >= wait_limit) begin
      give_up("chip logged fewer than ten frames");
    end
    wait_frame_end();
    @(negedge sclk);
    fresh = '1;
    check_bank();
    check_read(base + 0, '0);
    check_read(base + 1, '0);
    check_read(base + 10, '0);
    check_read(base - 256 + 2, '0);
    check_read(base + 256 + 2, '0);
    @(negedge sclk);
    assert (rd_valid === 1'b0) else flag_error("rd_valid held past one cycle");

    // Reset command wipes the bank, channels refill one per frame.
    wait_frame_end();
    @(negedge sclk);
    host_write(base + 0, cmd_reset);
    fresh = '0;
    check_bank();
    repeat (num_chan + 1) begin
      wait_frame_end();
      @(negedge sclk);
      fresh[model_i.last_tag] = 1'b1;
      check_bank();
    end
    // All other frames carried the idle word.
    assert (model_i.cmd_count == 2) else flag_error("chip saw an unexpected non-idle word");

    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verif/adc_serial_model.sv ====
/*
  Behavioral serial ADC chip.
  Answers each frame with a tagged random sample, MSB first,
  and logs the replies it sent and the command words it got.
*/
`timescale 1ns/1ps

module adc_serial_model (
  input  logic cs,
  input  logic adc_sclk,
  input  logic adc_din,
  output logic adc_dout
);
  import adc_pkg::*;

  // Random stream for the sample values.
  integer    seed;
  adc_word_t reply;
  adc_word_t rx_word;
  chan_t     tag;
  int        bit_idx;
  // Latest reply per channel.
  adc_word_t last_sent [num_chan];
  chan_t     last_tag;
  // Non-idle words seen on adc_din, in order.
  adc_word_t cmd_log [16];
  int        cmd_count;
  int        frame_count;

  initial begin
    seed        = 213;
    adc_dout    = 1'b0;
    tag         = '0;
    last_tag    = '0;
    bit_idx     = 0;
    cmd_count   = 0;
    frame_count = 0;
    reply       = '0;
    rx_word     = '0;
    for (int i = 0; i < num_chan; i++) begin
      last_sent[i] = '0;
    end
  end

  // New frame.
  // Tag in the top three bits, bit 12 zero, 12-bit value below.
  always @(posedge cs) begin
    reply   = {tag, 1'b0, 12'($random(seed))};
    rx_word = '0;
    bit_idx = 0;
  end

  // Rising edge: next reply bit out, one command bit in.
  always @(posedge adc_sclk) begin
    if (cs && bit_idx < frame_bits) begin
      adc_dout = reply[frame_bits-1-bit_idx];
      rx_word  = {rx_word[frame_bits-2:0], adc_din};
      bit_idx++;
    end
  end

  // Frame closed.
  // Only a full frame counts.
  always @(negedge cs) begin
    if (bit_idx == frame_bits) begin
      last_sent[tag] = reply;
      last_tag       = tag;
      if (rx_word != idle_word) begin
        if (cmd_count < 16) begin
          cmd_log[cmd_count] = rx_word;
        end
        cmd_count++;
      end
      frame_count++;
      tag     = tag + 1'b1;
      bit_idx = 0;
    end
  end

endmodule

// ==== vlog.f ====
src/adc_pkg.sv
src/adc_bus_regs.sv
src/adc_frame_engine.sv
src/adc_sample_bank.sv
src/adc_control.sv
verif/adc_serial_model.sv
verif/adc_control_tb.sv
